// File: list.f
+incdir+logic
logic/aes_pkg.sv
logic/wb_pkg.sv
logic/aes_sbox.sv
logic/round_key_rom.sv
logic/aes_round_engine.sv
logic/wb_reg_bank.sv
logic/result_buffer.sv
logic/aes_wb_top.sv
tests/tb_aes_wb.sv

// File: logic/aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// cipher rounds for a 128-bit key
`define AES_ROUNDS 10

// fixed key schedules held in the rom
`define AES_KEY_SLOTS 2

// wishbone data width
`define WB_DATA_W 32

// word address, 16 register slots
`define WB_ADR_W 4

`endif

// File: logic/aes_pkg.sv
package aes_pkg;

    // one byte of the cipher state
    typedef logic [7:0] byte_t;

    // one state column, row 0 in the top byte
    typedef logic [31:0] word_t;

    // full 128-bit state, byte 0 in the top bits
    typedef logic [127:0] block_t;

    // round index 0..10
    typedef logic [3:0] round_t;

    // round engine FSM
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        ROUND,
        FINAL
    } engine_state_e;

endpackage

// File: logic/aes_round_engine.sv
`timescale 1ns/1ns
`include "aes_defs.svh"

module aes_round_engine (
    input  logic             OK_addRK,
    input  logic             resetn,
    input  logic             start,
    input  logic             slot,
    input  aes_pkg::block_t  plaintext,
    input  aes_pkg::block_t  round_key,
    output aes_pkg::round_t  key_round,
    output logic             key_slot,
    output logic             busy,
    output logic             finished,
    output aes_pkg::block_t  ciphertext
);

    aes_pkg::engine_state_e fsm;
    aes_pkg::round_t        rnd;
    logic                   slot_q;
    aes_pkg::block_t        blk_q;
    aes_pkg::block_t        sb_blk;
    aes_pkg::block_t        sr_blk;
    aes_pkg::block_t        mc_blk;
    aes_pkg::block_t        nxt_blk;

    // multiply by x in GF(2^8)
    function automatic aes_pkg::byte_t xtime(input aes_pkg::byte_t b);
        xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // one column times the fixed 02 03 01 01 matrix
    function automatic aes_pkg::word_t mix_col(input aes_pkg::word_t w);
        aes_pkg::byte_t a0;
        aes_pkg::byte_t a1;
        aes_pkg::byte_t a2;
        aes_pkg::byte_t a3;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        mix_col = {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                   a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                   a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                   xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // SubBytes, all sixteen bytes at once
    for (genvar i = 0; i < 16; i++)
    begin : g_sbox
        aes_sbox i_sbox (
            .in_byte  (blk_q[127 - 8*i -: 8]),
            .out_byte (sb_blk[127 - 8*i -: 8])
        );
    end

    // ShiftRows, row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                sr_blk[127 - 8*(r + 4*c) -: 8] = sb_blk[127 - 8*(r + 4*((c + r) % 4)) -: 8];
            end
        end
    end

    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mc_blk[127 - 32*c -: 32] = mix_col(sr_blk[127 - 32*c -: 32]);
        end
    end

    // LOAD whitens the plaintext, FINAL skips MixColumns
    assign nxt_blk = ((fsm == aes_pkg::LOAD) ? plaintext :
                      (fsm == aes_pkg::FINAL) ? sr_blk : mc_blk) ^ round_key;

    // rom lags one cycle, so ask for the key of the next round
    assign key_round = (fsm == aes_pkg::LOAD || fsm == aes_pkg::ROUND) ?
                       aes_pkg::round_t'(rnd + 4'd1) : '0;
    // live slot while idle so key 0 is ready on entry to LOAD
    assign key_slot  = (fsm == aes_pkg::IDLE) ? slot : slot_q;

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            fsm      <= aes_pkg::IDLE;
            rnd      <= '0;
            slot_q   <= 1'b0;
            busy     <= 1'b0;
            finished <= 1'b0;
        end
        else
        begin
            finished <= 1'b0;
            case (fsm)
                aes_pkg::IDLE:
                begin
                    // start while busy never reaches here
                    if (start)
                    begin
                        fsm    <= aes_pkg::LOAD;
                        rnd    <= '0;
                        slot_q <= slot;
                        busy   <= 1'b1;
                    end
                end
                aes_pkg::LOAD:
                begin
                    fsm <= aes_pkg::ROUND;
                    rnd <= 4'd1;
                end
                aes_pkg::ROUND:
                begin
                    rnd <= rnd + 4'd1;
                    if (rnd == `AES_ROUNDS - 1)
                        fsm <= aes_pkg::FINAL;
                end
                aes_pkg::FINAL:
                begin
                    fsm      <= aes_pkg::IDLE;
                    busy     <= 1'b0;
                    finished <= 1'b1;
                end
            endcase
        end
    end

    // state register, plaintext is taken in LOAD only
    always_ff @(posedge OK_addRK)
    begin
        if (fsm != aes_pkg::IDLE)
            blk_q <= nxt_blk;
    end

    assign ciphertext = blk_q;

    a_finished_pulse: assert property (
        @(posedge OK_addRK) disable iff (!resetn) finished |=> !finished
    );

endmodule

// File: logic/aes_sbox.sv
`timescale 1ns/1ns

module aes_sbox (
    input  aes_pkg::byte_t in_byte,
    output aes_pkg::byte_t out_byte
);

    // one row of 16 table entries, picked by the high nibble
    logic [127:0] row;

    always_comb
    begin
        case (in_byte[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            4'hf: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
        endcase
    end

    // low nibble selects the column, entry 0 sits in the top byte
    assign out_byte = row[127 - 8*in_byte[3:0] -: 8];

endmodule

// File: logic/aes_wb_top.sv
`timescale 1ns/1ns
`include "aes_defs.svh"

module aes_wb_top (
    input  logic                  OK_addRK,
    input  logic                  resetn,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`WB_ADR_W-1:0]  wb_adr,
    input  logic [`WB_DATA_W-1:0] wb_dat_w,
    output logic [`WB_DATA_W-1:0] wb_dat_r,
    output logic                  wb_ack,
    output logic                  irq
);

    logic             start;
    logic             slot;
    aes_pkg::block_t  plaintext;
    logic             busy;
    logic             done;
    logic             finished;
    logic             ct_read_clear;
    aes_pkg::block_t  ciphertext;
    aes_pkg::block_t  stored_ct;
    aes_pkg::block_t  round_key;
    aes_pkg::round_t  key_round;
    logic             key_slot;

    // bus side registers
    wb_reg_bank i_reg_bank (
        .OK_addRK      (OK_addRK),
        .resetn        (resetn),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .busy          (busy),
        .done          (done),
        .stored_ct     (stored_ct),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .start         (start),
        .slot          (slot),
        .plaintext     (plaintext),
        .ct_read_clear (ct_read_clear)
    );

    aes_round_engine i_engine (
        .OK_addRK   (OK_addRK),
        .resetn     (resetn),
        .start      (start),
        .slot       (slot),
        .plaintext  (plaintext),
        .round_key  (round_key),
        .key_round  (key_round),
        .key_slot   (key_slot),
        .busy       (busy),
        .finished   (finished),
        .ciphertext (ciphertext)
    );

    // key schedules, addressed by the engine
    round_key_rom i_key_rom (
        .OK_addRK  (OK_addRK),
        .resetn    (resetn),
        .slot      (key_slot),
        .round     (key_round),
        .round_key (round_key)
    );

    result_buffer i_result_buf (
        .OK_addRK      (OK_addRK),
        .resetn        (resetn),
        .finished      (finished),
        .ciphertext    (ciphertext),
        .ct_read_clear (ct_read_clear),
        .stored_ct     (stored_ct),
        .done          (done),
        .irq           (irq)
    );

endmodule

// File: logic/result_buffer.sv
`timescale 1ns/1ns

module result_buffer (
    input  logic             OK_addRK,
    input  logic             resetn,
    input  logic             finished,
    input  aes_pkg::block_t  ciphertext,
    input  logic             ct_read_clear,
    output aes_pkg::block_t  stored_ct,
    output logic             done,
    output logic             irq
);

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            stored_ct <= '0;
            done      <= 1'b0;
        end
        else
        begin
            // a newer result simply replaces an unread one
            if (finished)
                stored_ct <= ciphertext;
            // set beats clear when both land together
            if (finished)
                done <= 1'b1;
            else if (ct_read_clear)
                done <= 1'b0;
        end
    end

    // level interrupt, drops with the CT3 read
    assign irq = done;

endmodule

// File: logic/round_key_rom.sv
`timescale 1ns/1ns
`include "aes_defs.svh"

module round_key_rom (
    input  logic             OK_addRK,
    input  logic             resetn,
    input  logic             slot,
    input  aes_pkg::round_t  round,
    output aes_pkg::block_t  round_key
);

    // precomputed schedules, slot 0 is the C.1 key, slot 1 the B key
    localparam aes_pkg::block_t KEYS [`AES_KEY_SLOTS][`AES_ROUNDS+1] = '{
        '{
            128'h000102030405060708090a0b0c0d0e0f,
            128'hd6aa74fdd2af72fadaa678f1d6ab76fe,
            128'hb692cf0b643dbdf1be9bc5006830b3fe,
            128'hb6ff744ed2c2c9bf6c590cbf0469bf41,
            128'h47f7f7bc95353e03f96c32bcfd058dfd,
            128'h3caaa3e8a99f9deb50f3af57adf622aa,
            128'h5e390f7df7a69296a7553dc10aa31f6b,
            128'h14f9701ae35fe28c440adf4d4ea9c026,
            128'h47438735a41c65b9e016baf4aebf7ad2,
            128'h549932d1f08557681093ed9cbe2c974e,
            128'h13111d7fe3944a17f307a78b4d2b30c5
        },
        '{
            128'h2b7e151628aed2a6abf7158809cf4f3c,
            128'ha0fafe1788542cb123a339392a6c7605,
            128'hf2c295f27a96b9435935807a7359f67f,
            128'h3d80477d4716fe3e1e237e446d7a883b,
            128'hef44a541a8525b7fb671253bdb0bad00,
            128'hd4d1c6f87c839d87caf2b8bc11f915bc,
            128'h6d88a37a110b3efddbf98641ca0093fd,
            128'h4e54f70e5f5fc9f384a64fb24ea6dc4f,
            128'head27321b58dbad2312bf5607f8d292f,
            128'hac7766f319fadc2128d12941575c006e,
            128'hd014f9a8c9ee2589e13f0cc8b6630ca6
        }
    };

    // one cycle read latency, engine requests a round ahead
    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
            round_key <= '0;
        else
            round_key <= KEYS[slot][round];
    end

    // index past the last round key would read outside the table
    a_round_in_range: assert property (
        @(posedge OK_addRK) disable iff (!resetn) round <= `AES_ROUNDS
    );

endmodule

// File: logic/wb_pkg.sv
`include "aes_defs.svh"

package wb_pkg;

    // register map, word addresses
    typedef enum logic [`WB_ADR_W-1:0] {
        CTRL   = 0,
        STATUS = 1,
        PT0    = 4,
        PT1    = 5,
        PT2    = 6,
        PT3    = 7,
        CT0    = 8,
        CT1    = 9,
        CT2    = 10,
        CT3    = 11
    } reg_addr_e;

    typedef logic [`WB_DATA_W-1:0] bus_word_t;

endpackage

// File: logic/wb_reg_bank.sv
`timescale 1ns/1ns
`include "aes_defs.svh"

module wb_reg_bank (
    input  logic                  OK_addRK,
    input  logic                  resetn,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`WB_ADR_W-1:0]  wb_adr,
    input  wb_pkg::bus_word_t     wb_dat_w,
    input  logic                  busy,
    input  logic                  done,
    input  aes_pkg::block_t       stored_ct,
    output wb_pkg::bus_word_t     wb_dat_r,
    output logic                  wb_ack,
    output logic                  start,
    output logic                  slot,
    output aes_pkg::block_t       plaintext,
    output logic                  ct_read_clear
);

    wb_pkg::reg_addr_e addr;
    wb_pkg::bus_word_t pt_q [4];
    logic              access;
    logic              ctrl_wr;

    assign addr = wb_pkg::reg_addr_e'(wb_adr);

    // single beat per request, ack blocks a second access
    assign access  = wb_cyc && wb_stb && !wb_ack;
    assign ctrl_wr = access && wb_we && (addr == wb_pkg::CTRL);

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            wb_ack        <= 1'b0;
            start         <= 1'b0;
            slot          <= 1'b0;
            ct_read_clear <= 1'b0;
        end
        else
        begin
            wb_ack        <= access;
            // start bit is self clearing
            start         <= ctrl_wr && wb_dat_w[0];
            ct_read_clear <= access && !wb_we && (addr == wb_pkg::CT3);
            if (ctrl_wr)
                slot <= wb_dat_w[1];
        end
    end

    // PT0..PT3 sit at 4..7, low address bits pick the word
    always_ff @(posedge OK_addRK)
    begin
        if (access && wb_we && addr inside {[wb_pkg::PT0:wb_pkg::PT3]})
            pt_q[wb_adr[1:0]] <= wb_dat_w;
    end

    // PT0 is the top word of the block
    assign plaintext = {pt_q[0], pt_q[1], pt_q[2], pt_q[3]};

    // read mux, unmapped addresses give zero
    always_comb
    begin
        wb_dat_r = '0;
        case (addr)
            wb_pkg::CTRL:
                wb_dat_r[1] = slot;
            wb_pkg::STATUS:
                wb_dat_r[1:0] = {done, busy};
            wb_pkg::PT0, wb_pkg::PT1, wb_pkg::PT2, wb_pkg::PT3:
                wb_dat_r = pt_q[wb_adr[1:0]];
            wb_pkg::CT0, wb_pkg::CT1, wb_pkg::CT2, wb_pkg::CT3:
                wb_dat_r = stored_ct[127 - 32*wb_adr[1:0] -: 32];
            default:
                wb_dat_r = '0;
        endcase
    end

    a_ack_after_stb: assert property (
        @(posedge OK_addRK) disable iff (!resetn) wb_ack |-> $past(wb_stb)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the AES Wishbone testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_aes_wb -f list.f -o sim_aes_wb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_aes_wb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
exit 1

// File: tests/tb_aes_wb.sv
`timescale 1ns/1ns
`include "aes_defs.svh"

module tb_aes_wb;

    // FIPS-197 known answer vectors
    localparam aes_pkg::block_t PT_A = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::block_t CT_A = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam aes_pkg::block_t PT_B = 128'h3243f6a8885a308d313198a2e0370734;
    localparam aes_pkg::block_t CT_B = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam int BUS_TIMEOUT  = 20;
    localparam int POLL_TIMEOUT = 40;

    logic                  OK_addRK;
    logic                  resetn;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`WB_ADR_W-1:0]  wb_adr;
    logic [`WB_DATA_W-1:0] wb_dat_w;
    logic [`WB_DATA_W-1:0] wb_dat_r;
    logic                  wb_ack;
    logic                  irq;
    int                    errors;
    int                    timeouts;

    aes_wb_top i_aes_wb_top (
        .OK_addRK (OK_addRK),
        .resetn   (resetn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .irq      (irq)
    );

    // 4 ns period
    always #2 OK_addRK = ~OK_addRK;

    task automatic compare_word(input string name, input wb_pkg::bus_word_t exp,
                                input wb_pkg::bus_word_t act);
        if (act !== exp)
        begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_block(input string name, input aes_pkg::block_t exp,
                                 input aes_pkg::block_t act);
        if (act !== exp)
        begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // one classic cycle, signals held until ack, sampled on the falling edge
    task automatic bus_transfer(input logic we, input logic [`WB_ADR_W-1:0] addr,
                                input wb_pkg::bus_word_t wdata,
                                output wb_pkg::bus_word_t rdata);
        int n;
        n = 0;
        @(negedge OK_addRK);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        while (wb_ack !== 1'b1 && n < BUS_TIMEOUT)
        begin
            @(negedge OK_addRK);
            n++;
        end
        if (wb_ack !== 1'b1)
        begin
            $display("timeout: no wb_ack for access to address %0d", addr);
            timeouts++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [`WB_ADR_W-1:0] addr, input wb_pkg::bus_word_t data);
        wb_pkg::bus_word_t unused;
        bus_transfer(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [`WB_ADR_W-1:0] addr, output wb_pkg::bus_word_t data);
        bus_transfer(1'b0, addr, '0, data);
    endtask

    // keeps reading STATUS until the masked bits match
    task automatic poll_status(input wb_pkg::bus_word_t mask, input wb_pkg::bus_word_t value,
                               input string what);
        wb_pkg::bus_word_t st;
        int n;
        n = 0;
        wb_read(wb_pkg::STATUS, st);
        while ((st & mask) != value && n < POLL_TIMEOUT)
        begin
            wb_read(wb_pkg::STATUS, st);
            n++;
        end
        if ((st & mask) != value)
        begin
            $display("timeout: STATUS never showed %s, engine in %s", what,
                     i_aes_wb_top.i_engine.fsm.name());
            timeouts++;
        end
    endtask

    task automatic wait_done();
        poll_status(32'h2, 32'h2, "done");
    endtask

    task automatic wait_idle();
        poll_status(32'h1, 32'h0, "busy low");
    endtask

    // PT0 carries the top word
    task automatic load_block(input aes_pkg::block_t pt);
        for (int i = 0; i < 4; i++)
            wb_write(4'(wb_pkg::PT0 + i), pt[127 - 32*i -: 32]);
    endtask

    task automatic start_run(input logic slot, input aes_pkg::block_t pt);
        load_block(pt);
        wb_write(wb_pkg::CTRL, {30'd0, slot, 1'b1});
    endtask

    task automatic read_ct(output aes_pkg::block_t ct);
        wb_pkg::bus_word_t d;
        for (int i = 0; i < 4; i++)
        begin
            wb_read(4'(wb_pkg::CT0 + i), d);
            ct[127 - 32*i -: 32] = d;
        end
    endtask

    task automatic reset_and_access();
        wb_pkg::bus_word_t d;
        aes_pkg::block_t ct;
        wb_read(wb_pkg::STATUS, d);
        compare_word("STATUS", '0, d);
        wb_read(wb_pkg::CTRL, d);
        compare_word("CTRL", '0, d);
        compare_bit("irq", 1'b0, irq);
        load_block(PT_B);
        for (int i = 0; i < 4; i++)
        begin
            wb_read(4'(wb_pkg::PT0 + i), d);
            compare_word($sformatf("PT%0d", i), PT_B[127 - 32*i -: 32], d);
        end
        read_ct(ct);
        compare_block("CT before run", '0, ct);
        // holes in the map
        wb_read(4'd3, d);
        compare_word("addr 3", '0, d);
        wb_read(4'd14, d);
        compare_word("addr 14", '0, d);
    endtask

    // full run, ciphertext check, then done cleared by the CT3 read
    task automatic known_answer(input logic slot, input aes_pkg::block_t pt,
                                input aes_pkg::block_t exp);
        wb_pkg::bus_word_t d;
        aes_pkg::block_t ct;
        start_run(slot, pt);
        wait_done();
        compare_bit("irq", 1'b1, irq);
        read_ct(ct);
        compare_block($sformatf("CT slot %0d", slot), exp, ct);
        wb_read(wb_pkg::STATUS, d);
        compare_word("STATUS after CT3", '0, d);
        compare_bit("irq", 1'b0, irq);
    endtask

    task automatic backpressure_in_flight();
        aes_pkg::block_t ct;
        start_run(1'b0, PT_A);
        // new PT and a second start while the block is in flight
        wb_write(wb_pkg::PT0, $urandom());
        wb_write(wb_pkg::PT1, $urandom());
        wb_write(wb_pkg::CTRL, 32'h1);
        wb_write(wb_pkg::PT2, $urandom());
        wb_write(wb_pkg::PT3, $urandom());
        wait_done();
        read_ct(ct);
        compare_block("CT under back-pressure", CT_A, ct);
        wait_idle();
    endtask

    task automatic result_overwrite();
        wb_pkg::bus_word_t d;
        aes_pkg::block_t ct;
        start_run(1'b1, PT_B);
        wait_done();
        start_run(1'b0, PT_A);
        wait_idle();
        wb_read(wb_pkg::STATUS, d);
        compare_word("STATUS after two runs", 32'h2, d);
        read_ct(ct);
        compare_block("CT after overwrite", CT_A, ct);
    endtask

    task automatic reset_mid_run();
        wb_pkg::bus_word_t d;
        aes_pkg::block_t ct;
        // unread result keeps done, irq and CT set going into the reset
        start_run(1'b1, PT_B);
        wait_done();
        start_run(1'b1, PT_B);
        wb_read(wb_pkg::STATUS, d);
        compare_word("STATUS before reset", 32'h3, d);
        compare_bit("irq before reset", 1'b1, irq);
        @(negedge OK_addRK);
        resetn = 1'b0;
        repeat (2) @(negedge OK_addRK);
        resetn = 1'b1;
        wb_read(wb_pkg::STATUS, d);
        compare_word("STATUS after reset", '0, d);
        compare_bit("irq", 1'b0, irq);
        read_ct(ct);
        compare_block("CT after reset", '0, ct);
        known_answer(1'b1, PT_B, CT_B);
    endtask

    initial
    begin
        void'($urandom(32'h3ee7_8cbe));
        errors   = 0;
        timeouts = 0;
        OK_addRK = 1'b0;
        resetn   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (2) @(negedge OK_addRK);
        resetn = 1'b1;
        reset_and_access();
        known_answer(1'b0, PT_A, CT_A);
        known_answer(1'b1, PT_B, CT_B);
        backpressure_in_flight();
        result_overwrite();
        reset_mid_run();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
